/* spi_flash_ctrl.f */
+incdir+include
logic/spi_xfer_pkg.sv
logic/wb_regmap_pkg.sv
logic/xfer_fifo.sv
logic/wb_spi_regs.sv
logic/spi_byte_engine.sv
logic/spi_flash_ctrl.sv
tb/spi_flash_model.sv
tb/spi_flash_ctrl_tb.sv

/* tb/spi_flash_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spi_flash_macros.svh"

module spi_flash_ctrl_tb;
    import wb_regmap_pkg::*;

    localparam int BYTE_CLKS  = 16 * `SPI_HALF_CYCLES;
    localparam int ACK_LIMIT  = 4 * BYTE_CLKS;
    localparam int IDLE_POLLS = 8 * BYTE_CLKS;
    localparam int RX_POLLS   = BYTE_CLKS;
    localparam int QUIET_CLKS = 3 * BYTE_CLKS;

    logic                  sys_clk;
    logic                  sys_rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    wb_reg_addr_t          wb_adr;
    logic [`WB_DATA_W-1:0] wb_dat_w;
    wire  [`WB_DATA_W-1:0] wb_dat_r;
    wire                   wb_ack;
    wire                   spi_cs_n;
    wire                   spi_sck;
    wire                   spi_mosi;
    wire                   spi_miso;

    int          error_count = 0;
    int          late_acks   = 0;
    int          sck_rises   = 0;
    logic        sck_prev    = 1'b0;
    logic [31:0] rng_state;

    spi_flash_ctrl dut0 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .spi_cs_n  (spi_cs_n),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso)
    );

    spi_flash_model flash0 (
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    // SCK rising edges inside a frame, seen from the system clock
    always @(posedge sys_clk) begin
        sck_prev <= spi_sck;
        if (spi_sck && !sck_prev && !spi_cs_n)
            sck_rises <= sck_rises + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Flash READ rule, low address byte XOR 0xA5
    function automatic logic [7:0] read_byte_at(input logic [23:0] addr, input int offset);
        logic [23:0] a;
        a = addr + offset;
        return a[7:0] ^ 8'hA5;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns %s expected 0x%08h got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic wb_transfer(input logic we, input wb_reg_addr_t adr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge sys_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        waited = 0;
        do begin
            @(posedge sys_clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        rdata = wb_dat_r;
        if (!wb_ack) begin
            error_count++;
            $display("Wishbone cycle to address %0d got no ack in %0d clocks", adr, waited);
        end else if (waited > 2)
            late_acks++;    // Ack seen after the second edge
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_reg_addr_t adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_transfer(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_reg_addr_t adr, output logic [31:0] data);
        wb_transfer(1'b0, adr, 32'd0, data);
    endtask

    task automatic queue_byte(input logic [7:0] data, input logic last, input logic capture);
        wb_write(REG_TXDATA, {22'd0, capture, last, data});   // TXDATA bits 9..0
    endtask

    task automatic queue_read_cmd(input logic [23:0] addr);
        queue_byte(8'h03, 1'b0, 1'b0);
        queue_byte(addr[23:16], 1'b0, 1'b0);
        queue_byte(addr[15:8], 1'b0, 1'b0);
        queue_byte(addr[7:0], 1'b0, 1'b0);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            wb_read(REG_STATUS, status);
            polls++;
        end while (status[ST_BUSY_BIT] && polls < IDLE_POLLS);
        if (status[ST_BUSY_BIT]) begin
            error_count++;
            $display("Controller still busy after %0d STATUS reads", polls);
        end
    endtask

    // Polls RXDATA until a byte is there
    task automatic expect_rx_byte(input string name, input logic [7:0] expected);
        logic [31:0] d;
        int          polls;
        polls = 0;
        do begin
            wb_read(REG_RXDATA, d);
            polls++;
        end while (!d[RXD_VALID_BIT] && polls < RX_POLLS);
        if (!d[RXD_VALID_BIT]) begin
            error_count++;
            $display("%s never arrived in RXDATA after %0d reads", name, polls);
        end else
            check(name, {23'd0, 1'b1, expected}, d);
    endtask

    task automatic wait_bus_stall();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < QUIET_CLKS && waited < 4 * QUIET_CLKS) begin
            @(posedge sys_clk);
            waited++;
            quiet = spi_sck ? 0 : quiet + 1;
        end
        if (quiet < QUIET_CLKS) begin
            error_count++;
            $display("SPI clock kept running, the bus did not stall");
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] d;
        check("spi_cs_n", 32'd1, spi_cs_n);
        check("spi_sck", 32'd0, spi_sck);
        check("spi_mosi", 32'd1, spi_mosi);
        wb_read(REG_STATUS, d);
        check("STATUS", 32'h2, d);   // Only rx_empty
        wb_read(REG_RXDATA, d);
        check("RXDATA", 32'h0, d);
        wb_read(2'd3, d);
        check("unmapped read", 32'h0, d);
    endtask

    task automatic test_write_enable();
        int rises_before;
        rises_before = sck_rises;
        queue_byte(8'h06, 1'b1, 1'b0);
        wait_idle();
        check("SCK rises in WREN frame", 32'd8, sck_rises - rises_before);
        check("spi_cs_n after WREN", 32'd1, spi_cs_n);
        queue_byte(8'h05, 1'b0, 1'b0);
        queue_byte(8'h00, 1'b1, 1'b1);
        wait_idle();
        expect_rx_byte("RDSR after WREN", 8'h02);
        queue_byte(8'h04, 1'b1, 1'b0);
        queue_byte(8'h05, 1'b0, 1'b0);
        queue_byte(8'h00, 1'b1, 1'b1);
        wait_idle();
        expect_rx_byte("RDSR after WRDI", 8'h00);
    endtask

    task automatic test_jedec_id();
        logic [31:0] d;
        queue_byte(8'h9F, 1'b0, 1'b0);
        queue_byte(8'h00, 1'b0, 1'b1);
        queue_byte(8'h00, 1'b0, 1'b1);
        queue_byte(8'h00, 1'b1, 1'b1);
        wait_idle();
        expect_rx_byte("JEDEC manufacturer", 8'hEF);
        expect_rx_byte("JEDEC type", 8'h40);
        expect_rx_byte("JEDEC capacity", 8'h18);
        wb_read(REG_RXDATA, d);
        check("RXDATA after JEDEC ID", 32'h0, d);
    endtask

    task automatic test_random_reads();
        logic [23:0] addr;
        logic [31:0] d;
        int          n;
        int          i;
        for (n = 0; n < 3; n++) begin
            rng_state = xorshift32(rng_state);
            addr = rng_state[23:0];
            queue_read_cmd(addr);
            for (i = 0; i < 4; i++)
                queue_byte(8'h00, i == 3, 1'b1);
            wait_idle();
            for (i = 0; i < 4; i++)
                expect_rx_byte("READ data", read_byte_at(addr, i));
            wb_read(REG_RXDATA, d);
            check("RXDATA after READ", 32'h0, d);
        end
    endtask

    task automatic test_back_pressure();
        logic [23:0] addr;
        logic [31:0] d;
        int          i;
        rng_state = xorshift32(rng_state);
        addr = rng_state[23:0];
        late_acks = 0;
        queue_read_cmd(addr);
        for (i = 0; i < 12; i++)
            queue_byte(8'h00, i == 11, 1'b1);
        check("late TXDATA acks seen", 32'd1, late_acks > 0);
        wait_bus_stall();
        wb_read(REG_STATUS, d);
        check("STATUS while stalled", 32'h5, d);   // tx_full and busy
        check("spi_cs_n while stalled", 32'd0, spi_cs_n);
        for (i = 0; i < 12; i++)
            expect_rx_byte("READ data after stall", read_byte_at(addr, i));
        wait_idle();
        wb_read(REG_RXDATA, d);
        check("RXDATA after drain", 32'h0, d);
    endtask

    initial begin
        sys_rst_n = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = REG_TXDATA;
        wb_dat_w  = '0;
        rng_state = 32'd68294;
        repeat (3) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(posedge sys_clk);
        test_reset_state();
        test_write_enable();
        test_jedec_id();
        test_random_reads();
        test_back_pressure();
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/spi_flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  wire  spi_cs_n,
    input  wire  spi_sck,
    input  wire  spi_mosi,
    output logic spi_miso
);
    logic [7:0]  opcode   = 8'h00;
    logic [7:0]  in_sr    = 8'h00;
    logic [7:0]  out_sr   = 8'hFF;
    logic [7:0]  next_out = 8'hFF;    // Byte shifted out during the next byte
    logic [23:0] addr     = 24'h0;
    logic        wel      = 1'b0;     // Write enable latch
    int          bit_cnt  = 0;
    int          byte_idx = 0;

    initial spi_miso = 1'b1;

    always @(negedge spi_cs_n) begin
        bit_cnt  = 0;
        byte_idx = 0;
        out_sr   = 8'hFF;
        spi_miso <= 1'b1;
    end

    // WREN and WRDI act when the frame closes
    always @(posedge spi_cs_n) begin
        if (byte_idx > 0 && opcode == 8'h06)
            wel = 1'b1;
        else if (byte_idx > 0 && opcode == 8'h04)
            wel = 1'b0;
    end

    always @(posedge spi_sck) begin
        if (!spi_cs_n) begin
            in_sr   = {in_sr[6:0], spi_mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                if (byte_idx == 0)
                    opcode = in_sr;
                case (opcode)
                    8'h05: next_out = {6'd0, wel, 1'b0};
                    8'h9F: begin
                        case (byte_idx)
                            0:       next_out = 8'hEF;
                            1:       next_out = 8'h40;
                            2:       next_out = 8'h18;
                            default: next_out = 8'h00;
                        endcase
                    end
                    8'h03: begin
                        if (byte_idx >= 1 && byte_idx <= 3)
                            addr = {addr[15:0], in_sr};   // Address MSB first
                        else if (byte_idx > 3)
                            addr = addr + 1'b1;
                        next_out = (byte_idx >= 3) ? (addr[7:0] ^ 8'hA5) : 8'hFF;
                    end
                    default: next_out = 8'hFF;
                endcase
                byte_idx = byte_idx + 1;
            end
        end
    end

    // Mode 0, MISO moves on the falling edge
    always @(negedge spi_sck) begin
        if (!spi_cs_n) begin
            if (bit_cnt == 0)
                out_sr = next_out;
            else
                out_sr = {out_sr[6:0], 1'b0};
            spi_miso <= out_sr[7];
        end
    end

endmodule

`default_nettype wire

/* logic/spi_flash_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spi_flash_macros.svh"

module spi_flash_ctrl (
    input  wire                              sys_clk,
    input  wire                              sys_rst_n,
    input  wire                              wb_cyc,
    input  wire                              wb_stb,
    input  wire                              wb_we,
    input  wire wb_regmap_pkg::wb_reg_addr_t wb_adr,
    input  wire [`WB_DATA_W-1:0]             wb_dat_w,
    output wire [`WB_DATA_W-1:0]             wb_dat_r,
    output wire                              wb_ack,
    output wire                              spi_cs_n,
    output wire                              spi_sck,
    output wire                              spi_mosi,
    input  wire                              spi_miso
);
    import spi_xfer_pkg::*;

    wire               tx_push;
    wire               tx_pop;
    wire               tx_full;
    wire               tx_empty;
    wire spi_tx_item_t tx_push_data;
    wire spi_tx_item_t tx_pop_data;

    wire               rx_push;
    wire               rx_pop;
    wire               rx_full;
    wire               rx_empty;
    wire spi_rx_byte_t rx_push_data;
    wire spi_rx_byte_t rx_pop_data;

    wire               engine_busy;

    wb_spi_regs regs0 (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .tx_push      (tx_push),
        .tx_push_data (tx_push_data),
        .tx_full      (tx_full),
        .tx_empty     (tx_empty),
        .rx_pop       (rx_pop),
        .rx_pop_data  (rx_pop_data),
        .rx_empty     (rx_empty),
        .engine_busy  (engine_busy)
    );

    xfer_fifo #(
        .DEPTH  (`TX_FIFO_DEPTH),
        .item_t (spi_tx_item_t)
    ) tx_fifo0 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .push      (tx_push),
        .push_data (tx_push_data),
        .pop       (tx_pop),
        .pop_data  (tx_pop_data),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    xfer_fifo #(
        .DEPTH  (`RX_FIFO_DEPTH),
        .item_t (spi_rx_byte_t)
    ) rx_fifo0 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .push      (rx_push),
        .push_data (rx_push_data),
        .pop       (rx_pop),
        .pop_data  (rx_pop_data),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    spi_byte_engine engine0 (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .item_empty (tx_empty),
        .item_data  (tx_pop_data),
        .item_pop   (tx_pop),
        .rx_full    (rx_full),
        .rx_push    (rx_push),
        .rx_data    (rx_push_data),
        .busy       (engine_busy),
        .spi_cs_n   (spi_cs_n),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

endmodule

`default_nettype wire

/* logic/spi_byte_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spi_flash_macros.svh"

module spi_byte_engine (
    input  wire                             sys_clk,
    input  wire                             sys_rst_n,
    input  wire                             item_empty,
    input  wire spi_xfer_pkg::spi_tx_item_t item_data,
    output logic                            item_pop,
    input  wire                             rx_full,
    output logic                            rx_push,
    output spi_xfer_pkg::spi_rx_byte_t      rx_data,
    output logic                            busy,
    output logic                            spi_cs_n,
    output logic                            spi_sck,
    output logic                            spi_mosi,
    input  wire                             spi_miso
);
    import spi_xfer_pkg::*;

    localparam int HALF = `SPI_HALF_CYCLES;
    localparam int HCW  = (HALF > 1) ? $clog2(HALF) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_TRAIL,   // SCK low, chip select still low
        ST_GUARD    // Chip select high before next frame
    } state_t;

    state_t         state;
    logic [HCW-1:0] half_cnt;
    logic [2:0]     bit_cnt;
    logic           last_r;
    logic           cap_r;
    logic [7:0]     tx_sr;
    spi_rx_byte_t   rx_sr;

    logic half_end;
    logic start_ok;
    logic rise_evt;
    logic fall_evt;
    logic byte_end;

    assign half_end = (half_cnt == HCW'(HALF - 1));
    // Capture items wait for room in the receive FIFO
    assign start_ok = !item_empty && !(item_data.capture && rx_full);
    assign rise_evt = (state == ST_SHIFT) && half_end && !spi_sck;
    assign fall_evt = (state == ST_SHIFT) && half_end && spi_sck;
    assign byte_end = fall_evt && (bit_cnt == 3'd7);

    // Next byte starts on the final falling edge when the frame goes on
    assign item_pop = start_ok && ((state == ST_IDLE) || (byte_end && !last_r));

    assign busy    = (state != ST_IDLE) || !spi_cs_n;
    assign rx_data = rx_sr;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= ST_IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
            last_r   <= 1'b0;
            cap_r    <= 1'b0;
            rx_push  <= 1'b0;
            spi_cs_n <= 1'b1;
            spi_sck  <= 1'b0;
            spi_mosi <= 1'b1;
        end else begin
            rx_push  <= rise_evt && (bit_cnt == 3'd7) && cap_r;
            half_cnt <= (state == ST_IDLE || half_end) ? '0 : half_cnt + 1'b1;

            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        state    <= ST_SHIFT;
                        spi_cs_n <= 1'b0;   // Same cycle as bit 7
                        spi_mosi <= item_data.data[7];
                    end
                end
                ST_SHIFT: begin
                    if (rise_evt) begin
                        spi_sck <= 1'b1;
                    end else if (fall_evt) begin
                        spi_sck <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;  // Wraps at byte end
                        if (!byte_end) begin
                            spi_mosi <= tx_sr[6];
                        end else if (last_r) begin
                            spi_mosi <= 1'b1;
                            state    <= ST_TRAIL;
                        end else if (start_ok) begin
                            spi_mosi <= item_data.data[7];
                        end else begin
                            // Frame stays open, bus stalls
                            spi_mosi <= 1'b1;
                            state    <= ST_IDLE;
                        end
                    end
                end
                ST_TRAIL: begin
                    if (half_end) begin
                        spi_cs_n <= 1'b1;
                        state    <= ST_GUARD;
                    end
                end
                ST_GUARD: begin
                    if (half_end)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase

            if (item_pop) begin
                last_r <= item_data.last;
                cap_r  <= item_data.capture;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (item_pop)
            tx_sr <= item_data.data;
        else if (fall_evt)
            tx_sr <= {tx_sr[6:0], 1'b0};
        if (rise_evt)
            rx_sr <= {rx_sr[6:0], spi_miso};  // MSB first
    end

    sck_low_while_deselected: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        spi_cs_n |-> !spi_sck)
        else $error("SCK high while chip select is high");

endmodule

`default_nettype wire

/* logic/wb_spi_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spi_flash_macros.svh"

module wb_spi_regs (
    input  wire                              sys_clk,
    input  wire                              sys_rst_n,
    input  wire                              wb_cyc,
    input  wire                              wb_stb,
    input  wire                              wb_we,
    input  wire wb_regmap_pkg::wb_reg_addr_t wb_adr,
    input  wire [`WB_DATA_W-1:0]             wb_dat_w,
    output logic [`WB_DATA_W-1:0]            wb_dat_r,
    output logic                             wb_ack,
    output logic                             tx_push,
    output spi_xfer_pkg::spi_tx_item_t       tx_push_data,
    input  wire                              tx_full,
    input  wire                              tx_empty,
    output logic                             rx_pop,
    input  wire spi_xfer_pkg::spi_rx_byte_t  rx_pop_data,
    input  wire                              rx_empty,
    input  wire                              engine_busy
);
    import wb_regmap_pkg::*;

    logic req;
    logic tx_write;
    logic rd_ack;

    assign req      = wb_cyc && wb_stb && !wb_ack;    // Masked in the ack cycle
    assign tx_write = wb_we && (wb_adr == REG_TXDATA);
    assign rd_ack   = wb_ack && !wb_we;

    // A write to a full transmit FIFO waits here until the engine pops
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= req && !(tx_write && tx_full);
    end

    // Request signals are still held during ack
    assign tx_push = wb_ack && tx_write;

    assign tx_push_data.data    = wb_dat_w[TXD_DATA_MSB:TXD_DATA_LSB];
    assign tx_push_data.last    = wb_dat_w[TXD_LAST_BIT];
    assign tx_push_data.capture = wb_dat_w[TXD_CAP_BIT];

    assign rx_pop = rd_ack && (wb_adr == REG_RXDATA) && !rx_empty;

    always_comb begin
        wb_dat_r = '0;
        if (rd_ack) begin
            case (wb_adr)
                REG_RXDATA: begin
                    wb_dat_r[RXD_VALID_BIT] = !rx_empty;
                    if (!rx_empty)
                        wb_dat_r[RXD_BYTE_MSB:RXD_BYTE_LSB] = rx_pop_data;
                end
                REG_STATUS: begin
                    wb_dat_r[ST_TX_FULL_BIT]  = tx_full;
                    wb_dat_r[ST_RX_EMPTY_BIT] = rx_empty;
                    // Queued bytes count as busy too
                    wb_dat_r[ST_BUSY_BIT]     = engine_busy || !tx_empty;
                end
                default: ;  // TXDATA and unmapped read as zero
            endcase
        end
    end

    // Push and pop above rely on the master holding its request through ack
    ack_with_request: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack without a held request");

endmodule

`default_nettype wire

/* logic/xfer_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module xfer_fifo #(
    parameter int  DEPTH  = 4,
    parameter type item_t = logic [7:0]
) (
    input  wire        sys_clk,
    input  wire        sys_rst_n,
    input  wire        push,
    input  wire item_t push_data,
    input  wire        pop,
    output item_t      pop_data,
    output logic       full,
    output logic       empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    // Wrap also works for depths that are not a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];  // Show-ahead head entry
    assign full     = (count == (AW + 1)'(DEPTH));
    assign empty    = (count == '0);

    no_push_when_full: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        push |-> !full)
        else $error("push into full FIFO");

    no_pop_when_empty: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        pop |-> !empty)
        else $error("pop from empty FIFO");

endmodule

`default_nettype wire

/* logic/wb_regmap_pkg.sv */
`default_nettype none

package wb_regmap_pkg;

    typedef logic [1:0] wb_reg_addr_t;  // Word address

    localparam wb_reg_addr_t REG_TXDATA = 2'd0;   // Write only
    localparam wb_reg_addr_t REG_RXDATA = 2'd1;   // Read only, pops
    localparam wb_reg_addr_t REG_STATUS = 2'd2;   // Read only

    localparam int TXD_DATA_MSB = 7;
    localparam int TXD_DATA_LSB = 0;
    localparam int TXD_LAST_BIT = 8;
    localparam int TXD_CAP_BIT  = 9;

    localparam int RXD_BYTE_MSB  = 7;
    localparam int RXD_BYTE_LSB  = 0;
    localparam int RXD_VALID_BIT = 8;

    localparam int ST_TX_FULL_BIT  = 0;
    localparam int ST_RX_EMPTY_BIT = 1;
    localparam int ST_BUSY_BIT     = 2;

endpackage

`default_nettype wire

/* logic/spi_xfer_pkg.sv */
`default_nettype none

package spi_xfer_pkg;

    // Transmit FIFO entry laid out like TXDATA bits 9 to 0
    typedef struct packed {
        logic       capture;    // Keep the MISO byte
        logic       last;       // Release chip select after this byte
        logic [7:0] data;
    } spi_tx_item_t;

    // Byte assembled from MISO
    typedef logic [7:0] spi_rx_byte_t;

endpackage

`default_nettype wire

/* include/spi_flash_macros.svh */
`ifndef SPI_FLASH_MACROS_SVH
`define SPI_FLASH_MACROS_SVH

// System clocks per SPI clock half period
`define SPI_HALF_CYCLES 5

// Queue depths in items
`define TX_FIFO_DEPTH 8
`define RX_FIFO_DEPTH 4

`define WB_DATA_W 32

`endif
